// File: source/pu_ctrl_pkg.sv
package pu_ctrl_pkg;

  // ================================================
  // widths and codes
  // ================================================
  localparam int INST_W       = 32;
  localparam int IMM_W        = 16;
  localparam int STRIDE_W     = 32;
  localparam int IMEM_ADDR_W  = 10;  // 1k words
  localparam int RF_ADDR_W    = 4;
  localparam int ALU_FN_W     = 3;
  localparam int ST_REQ_DELAY = 2;   // store issue to write request

  // stream select, low bits of an rf address with bit 3 set
  localparam logic [2:0] STREAM_OBUF = 3'd0;
  localparam logic [2:0] STREAM_LD0  = 3'd1;
  localparam logic [2:0] STREAM_LD1  = 3'd2;

  // ================================================
  // types
  // ================================================
  typedef logic [INST_W-1:0]      inst_t;
  typedef logic [IMM_W-1:0]       imm_t;
  typedef logic [STRIDE_W-1:0]    stride_t;
  typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;
  typedef logic [RF_ADDR_W-1:0]   rf_addr_t;
  typedef logic [ALU_FN_W-1:0]    alu_fn_t;
  typedef logic [2:0]             loop_type_t;
  typedef logic [3:0]             stride_type_t;
  typedef logic [1:0]             mem_type_t;
  typedef logic [2:0]             upsample_t;

  typedef enum logic [3:0] {
    SETUP        = 4'd0,
    LDMEM        = 4'd1,
    STMEM        = 4'd2,
    RDBUF        = 4'd3,
    WRBUF        = 4'd4,
    GENADDR_HI   = 4'd5,
    GENADDR_LO   = 4'd6,
    LOOP         = 4'd7,
    BLOCK_REPEAT = 4'd8,
    BASE_ADDR    = 4'd9,
    PU_BLOCK     = 4'd10,
    COMPUTE_R    = 4'd11,
    COMPUTE_I    = 4'd12
  } opcode_e;

  typedef enum logic [2:0] {IDLE, DECODE, COMPUTE_WAIT, COMPUTE, DONE} pu_state_e;

endpackage

// File: source/pu_inst_decode.sv
`timescale 1ns/1ps

module pu_inst_decode
  import pu_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         decode_active,
  input  logic         done,
  input  logic         inst_wr_req,
  input  inst_t        inst_wr_data,
  output logic         cfg_loop_iter_v,
  output imm_t         cfg_loop_iter,
  output loop_type_t   cfg_loop_iter_type,
  output logic         cfg_loop_stride_v,
  output stride_t      cfg_loop_stride,
  output stride_type_t cfg_loop_stride_type,
  output logic         cfg_mem_req_v,
  output mem_type_t    cfg_mem_req_type,
  output upsample_t    upsample_num,
  output logic         imem_wr,
  output logic         block_end,
  output imm_t         block_repeat
);

  opcode_e    opcode;
  logic [6:0] op_spec;
  imm_t       imm;
  imm_t       stride_hi;  // upper half of the next stride
  logic       inst_v;

  // opcode | op_spec | loop_id | imm, loop_id is not used here
  assign opcode  = opcode_e'(inst_wr_data[INST_W-1 -: 4]);
  assign op_spec = inst_wr_data[INST_W-5 -: 7];
  assign imm     = inst_wr_data[IMM_W-1:0];
  assign inst_v  = decode_active && inst_wr_req;

  assign cfg_loop_iter_v    = inst_v && (opcode == LOOP);
  assign cfg_loop_iter      = imm;
  assign cfg_loop_iter_type = op_spec[2:0];

  assign cfg_loop_stride_v    = inst_v && (opcode == GENADDR_LO);
  assign cfg_loop_stride      = {stride_hi, imm};
  assign cfg_loop_stride_type = op_spec[3:0];

  assign cfg_mem_req_v    = inst_v && (opcode == LDMEM);
  assign cfg_mem_req_type = op_spec[4:3];
  assign upsample_num     = op_spec[2:0];

  // compute words go to the instruction memory
  assign imem_wr      = inst_v && ((opcode == COMPUTE_R) || (opcode == COMPUTE_I));
  assign block_end    = (opcode == BLOCK_REPEAT);  // fsm qualifies it
  assign block_repeat = imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      stride_hi <= '0;
    end else if (cfg_loop_stride_v || done) begin
      stride_hi <= '0;  // one-shot, consumed by the low half
    end else if (inst_v && (opcode == GENADDR_HI)) begin
      stride_hi <= imm;
    end
  end

endmodule

// File: source/pu_inst_mem.sv
`timescale 1ns/1ps

module pu_inst_mem
  import pu_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  imem_wr,
  input  inst_t wr_data,
  input  logic  decode_active,
  input  logic  compute_active,
  input  logic  stall,
  input  logic  done,
  output inst_t rd_data,
  output logic  last_inst
);

  inst_t      mem [2**IMEM_ADDR_W];
  imem_addr_t wr_ptr;
  imem_addr_t last_addr;  // last written word
  imem_addr_t rd_ptr;     // address of the word now on rd_data
  imem_addr_t rd_addr;
  logic       rd_en;

  // ================================================
  // write side
  // ================================================
  always_ff @(posedge clk) begin
    if (imem_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      last_addr <= '0;
    end else begin
      if (done) begin
        wr_ptr <= '0;
      end else if (imem_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (imem_wr) begin
        last_addr <= wr_ptr;
      end
    end
  end

  // ================================================
  // read side
  // ================================================
  assign rd_en = decode_active || (compute_active && !stall);

  // decode parks on word 0, each issue steps to the next word and wraps
  assign rd_addr = decode_active          ? '0 :
                   (rd_ptr == last_addr)  ? '0 :
                                            rd_ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];  // lands one cycle later
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (done) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_addr;
    end
  end

  assign last_inst = (rd_ptr == last_addr);

endmodule

// File: source/pu_ctrl_fsm.sv
`timescale 1ns/1ps

module pu_ctrl_fsm
  import pu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      pu_block_start,
  input  logic      pu_compute_start,
  input  logic      block_end,
  input  logic      inst_wr_req,
  input  imm_t      block_repeat,
  input  logic      last_inst,
  input  logic      stall,
  output pu_state_e state,
  output logic      decode_active,
  output logic      compute_active,
  output logic      done,
  output logic      pu_compute_ready,
  output logic      inst_wr_ready
);

  pu_state_e state_nxt;
  imm_t      repeat_counter;  // passes left after this one
  imm_t      repeat_counter_nxt;
  logic      pass_end;

  assign pass_end = last_inst && !stall;  // last word of a pass issues

  always_comb begin
    state_nxt          = state;
    repeat_counter_nxt = repeat_counter;
    case (state)
      IDLE: begin
        if (pu_block_start) begin
          state_nxt = DECODE;
        end
      end
      DECODE: begin
        if (block_end && inst_wr_req) begin
          state_nxt          = COMPUTE_WAIT;
          repeat_counter_nxt = block_repeat;
        end
      end
      COMPUTE_WAIT: begin
        if (pu_compute_start) begin
          state_nxt = COMPUTE;
        end
      end
      COMPUTE: begin
        if (pass_end) begin
          if (repeat_counter == '0) begin
            state_nxt = DONE;
          end else begin
            repeat_counter_nxt = repeat_counter - 1'b1;
          end
        end
      end
      DONE:    state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= IDLE;
      repeat_counter <= '0;
    end else begin
      state          <= state_nxt;
      repeat_counter <= repeat_counter_nxt;
    end
  end

  assign decode_active    = (state == DECODE);
  assign compute_active   = (state == COMPUTE);
  assign done             = (state == DONE);
  assign pu_compute_ready = (state == COMPUTE_WAIT);
  assign inst_wr_ready    = (state != COMPUTE);

endmodule

// File: source/pu_issue_stall.sv
`timescale 1ns/1ps

module pu_issue_stall
  import pu_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     compute_active,
  input  inst_t    rd_data,
  input  logic     obuf_ld_stream_read_ready,
  input  logic     ddr_ld0_stream_read_ready,
  input  logic     ddr_ld1_stream_read_ready,
  input  logic     ddr_st_stream_write_ready,
  output logic     stall,
  output logic     alu_fn_valid,
  output alu_fn_t  alu_fn,
  output rf_addr_t alu_in0_addr,
  output rf_addr_t alu_in1_addr,
  output rf_addr_t alu_out_addr,
  output logic     alu_in1_src,
  output imm_t     alu_imm,
  output logic     obuf_ld_stream_read_req,
  output logic     ddr_ld0_stream_read_req,
  output logic     ddr_ld1_stream_read_req,
  output logic     ddr_st_stream_write_req
);

  logic                    need_obuf;
  logic                    need_ld0;
  logic                    need_ld1;
  logic                    need_st;
  logic [ST_REQ_DELAY-1:0] st_dly;  // store issues in flight

  // true when either operand reads the given stream
  function automatic logic uses_stream(input rf_addr_t in0, input rf_addr_t in1,
                                       input logic in1_src, input logic [2:0] code);
    return (in0[3] && (in0[2:0] == code)) ||
           (!in1_src && in1[3] && (in1[2:0] == code));
  endfunction

  assign {alu_in1_src, alu_fn, alu_imm, alu_in0_addr, alu_out_addr} = rd_data[INST_W-5:0];
  assign alu_in1_addr = alu_imm[RF_ADDR_W-1:0];  // register form reuses imm

  assign need_obuf = compute_active &&
                     uses_stream(alu_in0_addr, alu_in1_addr, alu_in1_src, STREAM_OBUF);
  assign need_ld0  = compute_active &&
                     uses_stream(alu_in0_addr, alu_in1_addr, alu_in1_src, STREAM_LD0);
  assign need_ld1  = compute_active &&
                     uses_stream(alu_in0_addr, alu_in1_addr, alu_in1_src, STREAM_LD1);
  assign need_st   = compute_active && alu_out_addr[3];

  assign stall = (need_obuf && !obuf_ld_stream_read_ready) ||
                 (need_ld0 && !ddr_ld0_stream_read_ready) ||
                 (need_ld1 && !ddr_ld1_stream_read_ready) ||
                 (need_st && !ddr_st_stream_write_ready);

  assign alu_fn_valid            = compute_active && !stall;
  assign obuf_ld_stream_read_req = need_obuf && !stall;
  assign ddr_ld0_stream_read_req = need_ld0 && !stall;
  assign ddr_ld1_stream_read_req = need_ld1 && !stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      st_dly <= '0;
    end else begin
      st_dly <= {st_dly[ST_REQ_DELAY-2:0], need_st && !stall};
    end
  end

  assign ddr_st_stream_write_req = st_dly[ST_REQ_DELAY-1];

endmodule

// File: source/pu_ctrl.sv
`timescale 1ns/1ps

module pu_ctrl
  import pu_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         pu_block_start,
  input  logic         pu_compute_start,
  output logic         pu_compute_ready,
  output logic         done,
  output pu_state_e    pu_ctrl_state,
  input  logic         inst_wr_req,
  input  inst_t        inst_wr_data,
  output logic         inst_wr_ready,
  output logic         cfg_loop_iter_v,
  output imm_t         cfg_loop_iter,
  output loop_type_t   cfg_loop_iter_type,
  output logic         cfg_loop_stride_v,
  output stride_t      cfg_loop_stride,
  output stride_type_t cfg_loop_stride_type,
  output logic         cfg_mem_req_v,
  output mem_type_t    cfg_mem_req_type,
  output upsample_t    upsample_num,
  output logic         alu_fn_valid,
  output alu_fn_t      alu_fn,
  output rf_addr_t     alu_in0_addr,
  output logic         alu_in1_src,
  output rf_addr_t     alu_in1_addr,
  output rf_addr_t     alu_out_addr,
  output imm_t         alu_imm,
  output logic         obuf_ld_stream_read_req,
  input  logic         obuf_ld_stream_read_ready,
  output logic         ddr_ld0_stream_read_req,
  input  logic         ddr_ld0_stream_read_ready,
  output logic         ddr_ld1_stream_read_req,
  input  logic         ddr_ld1_stream_read_ready,
  output logic         ddr_st_stream_write_req,
  input  logic         ddr_st_stream_write_ready
);

  logic  decode_active;
  logic  compute_active;
  logic  stall;
  logic  last_inst;
  logic  block_end;
  imm_t  block_repeat;
  logic  imem_wr;
  inst_t rd_data;  // current compute word

  pu_ctrl_fsm fsm_i (
    .state (pu_ctrl_state),
    .*
  );

  pu_inst_decode decode_i (.*);

  pu_inst_mem imem_i (
    .wr_data (inst_wr_data),
    .*
  );

  pu_issue_stall issue_i (.*);

endmodule

// File: verif/pu_ctrl_chk.sv
`timescale 1ns/1ps

module pu_ctrl_chk
  import pu_ctrl_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input pu_state_e pu_ctrl_state,
  input logic      done,
  input logic      alu_fn_valid,
  input alu_fn_t   alu_fn,
  input rf_addr_t  alu_in0_addr,
  input logic      alu_in1_src,
  input rf_addr_t  alu_out_addr,
  input imm_t      alu_imm,
  input logic      ddr_st_stream_write_req
);

  // the block ends only on an issue
  a_done_after_issue: assert property (@(posedge clk) disable iff (reset)
    done |-> $past(alu_fn_valid))
    else $error("done without an issue in the cycle before");

  // a stalled word stays on the ALU outputs
  a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
    ((pu_ctrl_state == COMPUTE) && !alu_fn_valid) |=>
      ((pu_ctrl_state == COMPUTE) &&
       $stable({alu_in1_src, alu_fn, alu_imm, alu_in0_addr, alu_out_addr})))
    else $error("ALU word or state changed during a stall");

  a_st_req_delay: assert property (@(posedge clk) disable iff (reset)
    ddr_st_stream_write_req == $past(alu_fn_valid && alu_out_addr[3], ST_REQ_DELAY))
    else $error("store write request not ST_REQ_DELAY cycles after a store issue");

endmodule

// File: verif/tb_pu_ctrl.sv
`timescale 1ns/1ps

module tb_pu_ctrl
  import pu_ctrl_pkg::*;
;

  localparam logic [1:0] K_NONE = 2'd0, K_ITER = 2'd1, K_STRIDE = 2'd2, K_MEM = 2'd3;

  typedef struct packed {
    inst_t      word;
    logic [1:0] kind;   // which strobe the word raises
    stride_t    field;  // expected iter, stride or upsample
    logic [3:0] typ;    // expected type field
  } step_t;

  logic clk, reset, pu_block_start, pu_compute_start, pu_compute_ready, done;
  pu_state_e pu_ctrl_state;
  logic inst_wr_req, inst_wr_ready;
  inst_t inst_wr_data;
  logic cfg_loop_iter_v, cfg_loop_stride_v, cfg_mem_req_v;
  imm_t cfg_loop_iter;
  loop_type_t cfg_loop_iter_type;
  stride_t cfg_loop_stride;
  stride_type_t cfg_loop_stride_type;
  mem_type_t cfg_mem_req_type;
  upsample_t upsample_num;
  logic alu_fn_valid, alu_in1_src;
  alu_fn_t alu_fn;
  rf_addr_t alu_in0_addr, alu_in1_addr, alu_out_addr;
  imm_t alu_imm;
  logic obuf_ld_stream_read_req, obuf_ld_stream_read_ready;
  logic ddr_ld0_stream_read_req, ddr_ld0_stream_read_ready;
  logic ddr_ld1_stream_read_req, ddr_ld1_stream_read_ready;
  logic ddr_st_stream_write_req, ddr_st_stream_write_ready;

  step_t       steps [$];
  inst_t       model [$];  // compute words of the current block
  logic [31:0] lcg_state;
  int          wd_cycles, err_count, issue_idx, total, step_i, blk_words;
  logic        compute_on, done_due, blk_end;
  logic [1:0]  st_hist;    // expected store requests in flight
  inst_t       word;
  logic [2:0]  need;
  logic        ok;

  pu_ctrl pu_ctrl_i (.*);

  bind pu_ctrl pu_ctrl_chk chk_i (.*);

  always #10 clk = ~clk;

  // ================================================
  // helpers
  // ================================================
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic inst_t prog_word(input opcode_e op, input logic [6:0] spec, input imm_t imm);
    return {op, spec, 5'd0, imm};
  endfunction

  function automatic inst_t alu_word(input opcode_e op, input logic src, input alu_fn_t fn,
                                     input imm_t imm, input rf_addr_t in0, input rf_addr_t out);
    return {op, src, fn, imm, in0, out};
  endfunction

  // {ld1, ld0, obuf} used by a stored word
  function automatic logic [2:0] stream_use(input inst_t w);
    logic [2:0] u;
    for (int c = 0; c < 3; c++) begin
      u[c] = (w[7] && (w[6:4] == c)) || (!w[27] && w[11] && (w[10:8] == c));
    end
    return u;
  endfunction

  task automatic add_step(input inst_t w, input logic [1:0] k, input stride_t f,
                          input logic [3:0] t);
    steps.push_back({w, k, f, t});
  endtask

  task automatic report_fail(input string msg);
    err_count++;
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) report_fail($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  task automatic check_inst(input inst_t got, input inst_t exp, input string what);
    if (got !== exp) report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_imm(input imm_t got, input imm_t exp, input string what);
    if (got !== exp) report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_stride(input stride_t got, input stride_t exp, input string what);
    if (got !== exp) report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_rf(input rf_addr_t got, input rf_addr_t exp, input string what);
    if (got !== exp) report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_fn(input alu_fn_t got, input alu_fn_t exp, input string what);
    if (got !== exp) report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_field(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_state(input pu_state_e got, input pu_state_e exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
    end
  endtask

  task automatic check_step(input step_t s);
    check_bit(cfg_loop_iter_v, s.kind == K_ITER, "loop iteration strobe");
    check_bit(cfg_loop_stride_v, s.kind == K_STRIDE, "loop stride strobe");
    check_bit(cfg_mem_req_v, s.kind == K_MEM, "memory request strobe");
    if (s.kind == K_ITER) begin
      check_imm(cfg_loop_iter, s.field[15:0], "loop iteration count");
      check_field(cfg_loop_iter_type, s.typ, "loop type");
    end else if (s.kind == K_STRIDE) begin
      check_stride(cfg_loop_stride, s.field, "loop stride");
      check_field(cfg_loop_stride_type, s.typ, "stride type");
    end else if (s.kind == K_MEM) begin
      check_field(cfg_mem_req_type, s.typ, "memory request type");
      check_field(upsample_num, s.field[3:0], "upsample count");
    end
  endtask

  task automatic quiet_check();
    check_bit(cfg_loop_iter_v | cfg_loop_stride_v | cfg_mem_req_v, 1'b0, "idle strobes");
    check_bit(done, 1'b0, "done while not finishing");
  endtask

  // ================================================
  // ready generator and issue monitor
  // ================================================
  always @(posedge clk) begin
    #2;
    lcg_state = lcg_next(lcg_state);
    obuf_ld_stream_read_ready = lcg_state[31] | lcg_state[30];  // about 3 in 4 ready
    ddr_ld0_stream_read_ready = lcg_state[29] | lcg_state[28];
    ddr_ld1_stream_read_ready = lcg_state[27] | lcg_state[26];
    ddr_st_stream_write_ready = lcg_state[25] | lcg_state[24];
  end

  always @(negedge clk) begin
    if (reset) begin
      st_hist = '0;
    end else begin
      check_bit(ddr_st_stream_write_req, st_hist[1], "store write request");
      st_hist = {st_hist[0], 1'b0};
      check_bit(done, done_due, "done pulse");
      done_due = 1'b0;
      if (compute_on) begin
        word = model[issue_idx % model.size()];
        need = stream_use(word);
        ok = !((need[0] && !obuf_ld_stream_read_ready) ||
               (need[1] && !ddr_ld0_stream_read_ready) ||
               (need[2] && !ddr_ld1_stream_read_ready) ||
               (word[3] && !ddr_st_stream_write_ready));
        check_state(pu_ctrl_state, COMPUTE, "state while issuing");
        check_bit(inst_wr_ready, 1'b0, "inst_wr_ready in COMPUTE");
        check_inst({word[31:28], alu_in1_src, alu_fn, alu_imm, alu_in0_addr, alu_out_addr},
                   word, "issued ALU word");
        check_fn(alu_fn, word[26:24], "alu_fn");
        check_rf(alu_in1_addr, word[11:8], "alu_in1_addr");
        check_bit(alu_fn_valid, ok, "alu_fn_valid");
        check_bit(obuf_ld_stream_read_req, need[0] && ok, "obuf read request");
        check_bit(ddr_ld0_stream_read_req, need[1] && ok, "ld0 read request");
        check_bit(ddr_ld1_stream_read_req, need[2] && ok, "ld1 read request");
        if (ok) begin
          st_hist[0] = word[3];
          issue_idx++;
          if (issue_idx == total) begin
            compute_on = 1'b0;
            done_due   = 1'b1;  // done follows the last issue
          end
        end
      end else begin
        check_bit(alu_fn_valid, 1'b0, "alu_fn_valid outside compute");
        check_bit(obuf_ld_stream_read_req | ddr_ld0_stream_read_req | ddr_ld1_stream_read_req,
                  1'b0, "read request outside compute");
      end
    end
  end

  // ================================================
  // watchdog
  // ================================================
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("ERROR: the run timed out after %0d cycles before all blocks finished", wd_cycles);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  // ================================================
  // main sequence
  // ================================================
  initial begin
    clk = 0;
    reset = 1;
    pu_block_start = 0;
    pu_compute_start = 0;
    inst_wr_req = 0;
    inst_wr_data = '0;
    obuf_ld_stream_read_ready = 0;
    ddr_ld0_stream_read_ready = 0;
    ddr_ld1_stream_read_ready = 0;
    ddr_st_stream_write_ready = 0;
    lcg_state = 32'hc629_473f;
    err_count = 0;
    wd_cycles = 0;
    compute_on = 0;
    done_due = 0;
    st_hist = '0;
    issue_idx = 0;
    total = 0;

    // first block of three passes over four words
    add_step(prog_word(LOOP, 7'h05, 16'd12), K_ITER, 32'd12, 4'h5);
    add_step(prog_word(GENADDR_HI, 7'h00, 16'hABCD), K_NONE, '0, '0);
    add_step(prog_word(GENADDR_LO, 7'h0C, 16'h1234), K_STRIDE, 32'hABCD_1234, 4'hC);
    add_step(prog_word(GENADDR_LO, 7'h03, 16'h0055), K_STRIDE, 32'h0000_0055, 4'h3);
    add_step(prog_word(LDMEM, 7'h1A, 16'h0000), K_MEM, 32'd2, 4'h3);
    add_step(alu_word(COMPUTE_R, 1'b0, 3'd1, 16'h0009, 4'h8, 4'h3), K_NONE, '0, '0);
    add_step(alu_word(COMPUTE_I, 1'b1, 3'd2, 16'h00AA, 4'h2, 4'h8), K_NONE, '0, '0);
    add_step(alu_word(COMPUTE_R, 1'b0, 3'd5, 16'h000A, 4'hA, 4'h9), K_NONE, '0, '0);
    add_step(alu_word(COMPUTE_R, 1'b0, 3'd7, 16'h0001, 4'hB, 4'h2), K_NONE, '0, '0);
    add_step(prog_word(GENADDR_HI, 7'h00, 16'hBEEF), K_NONE, '0, '0);  // left pending
    add_step(prog_word(BLOCK_REPEAT, 7'h00, 16'd2), K_NONE, '0, '0);
    // second block starts with no pending high half
    add_step(prog_word(GENADDR_LO, 7'h01, 16'h0077), K_STRIDE, 32'h0000_0077, 4'h1);
    add_step(prog_word(LOOP, 7'h7A, 16'd3), K_ITER, 32'd3, 4'h2);
    add_step(prog_word(LDMEM, 7'h0D, 16'h0000), K_MEM, 32'd5, 4'h1);
    add_step(alu_word(COMPUTE_I, 1'b1, 3'd3, 16'h1234, 4'h9, 4'h8), K_NONE, '0, '0);
    add_step(alu_word(COMPUTE_R, 1'b0, 3'd4, 16'h000B, 4'h3, 4'h0), K_NONE, '0, '0);
    add_step(prog_word(BLOCK_REPEAT, 7'h00, 16'd1), K_NONE, '0, '0);

    blk_words = 0;
    for (int i = 0; i < steps.size(); i++) begin
      if (steps[i].word[31:28] inside {COMPUTE_R, COMPUTE_I}) blk_words++;
      if (steps[i].word[31:28] == BLOCK_REPEAT) begin
        total += blk_words * (steps[i].word[15:0] + 1);
        blk_words = 0;
      end
    end
    wd_cycles = total * 40 + 200;

    repeat (5) @(posedge clk);
    #2 reset = 0;
    @(negedge clk);
    check_state(pu_ctrl_state, IDLE, "state after reset");
    check_bit(inst_wr_ready, 1'b1, "inst_wr_ready after reset");
    check_bit(pu_compute_ready, 1'b0, "pu_compute_ready after reset");
    check_bit(ddr_st_stream_write_req, 1'b0, "store request after reset");
    quiet_check();

    step_i = 0;
    while (step_i < steps.size()) begin
      @(posedge clk);
      #2 pu_block_start = 1;
      @(posedge clk);
      #2 pu_block_start = 0;
      model.delete();
      blk_end = 0;
      while (!blk_end) begin
        inst_wr_req  = 1;
        inst_wr_data = steps[step_i].word;
        #5 check_step(steps[step_i]);
        if (inst_wr_data[31:28] inside {COMPUTE_R, COMPUTE_I}) model.push_back(inst_wr_data);
        if (inst_wr_data[31:28] == BLOCK_REPEAT) begin
          total   = model.size() * (inst_wr_data[15:0] + 1);
          blk_end = 1;
        end
        step_i++;
        @(posedge clk);
        #2;
      end
      inst_wr_req = 0;
      #5;
      check_state(pu_ctrl_state, COMPUTE_WAIT, "state after block repeat");
      check_bit(pu_compute_ready, 1'b1, "pu_compute_ready");
      quiet_check();
      issue_idx = 0;
      @(posedge clk);
      #2 pu_compute_start = 1;
      @(posedge clk);
      #2 pu_compute_start = 0;
      compute_on = 1;
      wait (done === 1'b1);
      #1;
      check_state(pu_ctrl_state, DONE, "state at done");
      check_bit(inst_wr_ready, 1'b1, "inst_wr_ready at done");
      check_bit(issue_idx == total, 1'b1, "issue count at done");
    end

    repeat (3) @(posedge clk);
    #5;
    check_state(pu_ctrl_state, IDLE, "state at the end");
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: pu_ctrl

sources:
  - source/pu_ctrl_pkg.sv
  - source/pu_inst_decode.sv
  - source/pu_inst_mem.sv
  - source/pu_ctrl_fsm.sv
  - source/pu_issue_stall.sv
  - source/pu_ctrl.sv
  - target: test
    files:
      - verif/pu_ctrl_chk.sv
      - verif/tb_pu_ctrl.sv

// File: pu_ctrl.f
source/pu_ctrl_pkg.sv
source/pu_inst_decode.sv
source/pu_inst_mem.sv
source/pu_ctrl_fsm.sv
source/pu_issue_stall.sv
source/pu_ctrl.sv
verif/pu_ctrl_chk.sv
verif/tb_pu_ctrl.sv
